/* tests/core_trace.txt */
// Word 0 is the program length, then the program words from address 0
// Then store address and data pairs per test, fffffff0 closes a test, ffffffff ends the trace
00000038
123450b7 67808093 fff00113 0020c1b3 00400293 4051d233 40120333 10602023
0020b3b3 00509433 0083e4b3 10902223 10402423
10402583 00158633 10c02623 20002683 10d02823
00728463 001a0a13 00528663 3e002823 3e002a23
00529463 001a0a13 00729663 3e002823 3e002a23
0022c463 001a0a13 00514663 3e002823 3e002a23
00515463 001a0a13 0022d663 3e002823 3e002a23
00516463 001a0a13 0022e663 3e002823 3e002a23
0022f463 001a0a13 00517663 3e002823 3e002a23
11402a23
05500013 10002c23
10102e23 11c02783 12f02023 12302223 00000063
// Expected stores
00000100 eca86420
00000104 23456781
00000108 fedcba98 fffffff0
0000010c 3579bdf9
00000110 c2de0200 fffffff0
00000114 00000006 fffffff0
00000118 00000000 fffffff0
0000011c 12345678
00000120 12345678
00000124 edcba987 fffffff0 ffffffff

/* tb.f */
design/rv_pkg.sv
design/fetch_stage.sv
design/decoder.sv
design/regfile.sv
design/hazard_unit.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/rv_core.sv
tests/tb_core.sv

/* Makefile */
TOP := tb_core

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -Mdir obj_dir -f tb.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf obj_dir

/* tests/tb_core.sv */
`timescale 1ns/1ps

module tb_core;

    localparam int NUM_TESTS   = 6;
    localparam int TRACE_WORDS = 256;
    localparam int MEM_WORDS   = 256;
    localparam int DRAIN       = 20;  // Quiet cycles watched after the last store
    localparam rv_pkg::word_t TEST_END  = 32'hFFFF_FFF0;  // Closes the stores of one test
    localparam rv_pkg::word_t TRACE_END = 32'hFFFF_FFFF;

    logic          clk;
    logic          reset;
    rv_pkg::word_t imem_addr;
    rv_pkg::word_t imem_rdata;
    logic          imem_read;
    logic          imem_resp;
    rv_pkg::word_t dmem_addr;
    rv_pkg::word_t dmem_wdata;
    rv_pkg::word_t dmem_rdata;
    logic          dmem_read;
    logic          dmem_write;
    logic          dmem_resp;

    rv_pkg::word_t trace [TRACE_WORDS];
    rv_pkg::word_t imem [MEM_WORDS];
    rv_pkg::word_t dmem [MEM_WORDS];
    string         test_names [NUM_TESTS];
    int            prog_len;
    int            cursor;       // Next unread trace entry
    int            test_idx;
    int            errors;
    int            errors_mark;  // Error count when the current test began
    int            passed;
    int            cycles;
    int            limit;
    logic          trace_done;

    rv_core dut_i (
        .i_clk(clk), .i_reset(reset),
        .i_i_mem_rdata(imem_rdata), .i_i_mem_resp(imem_resp),
        .i_d_mem_rdata(dmem_rdata), .i_d_mem_resp(dmem_resp),
        .o_i_mem_address(imem_addr), .o_i_mem_read(imem_read),
        .o_d_mem_address(dmem_addr), .o_d_mem_wdata(dmem_wdata),
        .o_d_mem_read(dmem_read), .o_d_mem_write(dmem_write)
    );

    // Both memories answer in the same cycle
    assign imem_rdata = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem_read ? dmem[dmem_addr[9:2]] : 'x;  // Data only under the read strobe

    function automatic rv_pkg::word_t fill_word(input rv_pkg::word_t addr);
        return 32'hC0DE_0000 ^ (addr * 32'h0001_0001);
    endfunction

    task automatic check_store_addr(input rv_pkg::word_t got, input rv_pkg::word_t exp);
        if (got !== exp) begin
            $display("FAIL %0t: store address %h, expected %h", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_store_data(input rv_pkg::word_t got, input rv_pkg::word_t exp);
        if (got !== exp) begin
            $display("FAIL %0t: store data %h, expected %h", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_fetch_addr(input rv_pkg::word_t got, input rv_pkg::word_t exp);
        if (got !== exp) begin
            $display("FAIL %0t: fetch address %h, expected %h", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_strobe(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %0s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test();
        int n;
        n = errors - errors_mark;
        if (n == 0) begin
            passed++;
        end
        $display("Test %0d (%0s): %0s, %0d errors", test_idx + 1, test_names[test_idx],
                 (n == 0) ? "ok" : "failed", n);
        errors_mark = errors;
        test_idx++;
    endtask

    // Address entries left between the cursor and the end of the trace
    function automatic int count_missing();
        int n;
        int i;
        n = 0;
        i = cursor;
        while (i < TRACE_WORDS && trace[i] != TRACE_END) begin
            if (trace[i] == TEST_END) begin
                i++;
            end else begin
                n++;
                i += 2;
            end
        end
        return n;
    endfunction

    task automatic take_store(input rv_pkg::word_t addr, input rv_pkg::word_t data);
        if (trace_done) begin
            $display("FAIL %0t: extra store of %h to %h after the trace ended", $time, data, addr);
            errors++;
        end else begin
            check_store_addr(addr, trace[cursor]);
            check_store_data(data, trace[cursor + 1]);
            cursor += 2;
            if (trace[cursor] == TEST_END) begin
                finish_test();
                cursor++;
                trace_done = (trace[cursor] == TRACE_END);
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Strobes settle well before the falling edge
    always @(negedge clk) begin
        if (reset) begin
            check_strobe(dmem_read, 1'b0, "data read during reset");
            check_strobe(dmem_write, 1'b0, "data write during reset");
        end
        if (dmem_write && dmem_resp) begin  // Commits at the next rising edge
            dmem[dmem_addr[9:2]] = dmem_wdata;
            take_store(dmem_addr, dmem_wdata);
        end
    end

    // Each response drops with 25 % probability
    always @(posedge clk) begin
        if (!reset) begin
            cycles++;
            #1;
            imem_resp <= ($urandom % 4) != 0;
            dmem_resp <= ($urandom % 4) != 0;
        end
    end

    initial begin
        void'($urandom(60883));
        reset       = 1'b1;
        imem_resp   = 1'b1;
        dmem_resp   = 1'b1;
        errors      = 0;
        errors_mark = 0;
        passed      = 0;
        test_idx    = 0;
        cycles      = 0;
        trace_done  = 1'b0;
        test_names  = '{"reset", "alu and forwarding", "load-use", "branches",
                        "x0 write", "back-pressure"};
        for (int i = 0; i < TRACE_WORDS; i++) begin
            trace[i] = TRACE_END;
        end
        $readmemh("tests/core_trace.txt", trace);
        prog_len = trace[0];
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = (i < prog_len) ? trace[i + 1] : rv_pkg::NOP_INSTR;
            dmem[i] = fill_word(i * 4);
        end
        cursor = prog_len + 1;
        limit  = 20 * prog_len + 200;

        repeat (10) @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        check_fetch_addr(imem_addr, rv_pkg::RESET_PC);
        check_strobe(imem_read, 1'b1, "instruction read");
        finish_test();

        while (!trace_done && cycles < limit) begin
            @(posedge clk);
        end
        if (trace_done) begin
            repeat (DRAIN) @(posedge clk);  // Any store here is a duplicate
        end else begin
            $display("Run did not complete within %0d cycles, %0d stores missing",
                     limit, count_missing());
        end
        $display("Done: %0d of %0d tests passed, %0d errors", passed, NUM_TESTS, errors);
        if (trace_done && errors == 0 && passed == NUM_TESTS) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* design/rv_core.sv */
`timescale 1ns/1ps

module rv_core (
    input  logic          i_clk,
    input  logic          i_reset,
    input  rv_pkg::word_t i_i_mem_rdata,
    input  logic          i_i_mem_resp,
    input  rv_pkg::word_t i_d_mem_rdata,
    input  logic          i_d_mem_resp,
    output rv_pkg::word_t o_i_mem_address,
    output logic          o_i_mem_read,
    output rv_pkg::word_t o_d_mem_address,
    output rv_pkg::word_t o_d_mem_wdata,
    output logic          o_d_mem_read,
    output logic          o_d_mem_write
);

    rv_pkg::word_t      id_instr;
    rv_pkg::word_t      id_pc;
    rv_pkg::reg_addr_t  id_rs1;
    rv_pkg::reg_addr_t  id_rs2;
    rv_pkg::reg_addr_t  id_rd;
    rv_pkg::word_t      id_imm;
    rv_pkg::alu_op_t    id_alu_op;
    rv_pkg::branch_op_t id_branch_op;
    logic               id_use_imm;
    logic               id_uses_rs1;
    logic               id_uses_rs2;
    logic               id_reg_write;
    logic               id_mem_read;
    logic               id_mem_write;
    logic               id_is_branch;
    rv_pkg::word_t      rs1_data;
    rv_pkg::word_t      rs2_data;

    rv_pkg::fwd_sel_t   fwd_a;
    rv_pkg::fwd_sel_t   fwd_b;
    logic               load_front;
    logic               load_ex;
    logic               load_mem;
    logic               bubble_mem;

    rv_pkg::reg_addr_t  ex_rs1;
    rv_pkg::reg_addr_t  ex_rs2;
    rv_pkg::reg_addr_t  ex_rd;
    logic               ex_uses_rs1;
    logic               ex_uses_rs2;
    logic               ex_reg_write;
    logic               ex_mem_read;
    logic               ex_mem_write;
    rv_pkg::word_t      ex_alu_result;
    rv_pkg::word_t      ex_store_data;
    logic               branch_taken;
    rv_pkg::word_t      branch_target;

    rv_pkg::reg_addr_t  mem_rd;
    logic               mem_reg_write;
    logic               mem_is_load;
    logic               mem_access;
    rv_pkg::word_t      mem_result;
    rv_pkg::reg_addr_t  wb_rd;
    logic               wb_write;
    rv_pkg::word_t      wb_result;

    assign o_i_mem_read = 1'b1;  // Fetch every cycle

    fetch_stage u_fetch (
        .i_clk(i_clk), .i_reset(i_reset), .i_load(load_front),
        .i_branch_taken(branch_taken), .i_branch_target(branch_target),
        .i_instr(i_i_mem_rdata), .o_pc(o_i_mem_address),
        .o_id_instr(id_instr), .o_id_pc(id_pc)
    );

    decoder u_decoder (
        .i_instr(id_instr), .o_rs1(id_rs1), .o_rs2(id_rs2), .o_rd(id_rd),
        .o_imm(id_imm), .o_alu_op(id_alu_op), .o_use_imm(id_use_imm),
        .o_uses_rs1(id_uses_rs1), .o_uses_rs2(id_uses_rs2), .o_reg_write(id_reg_write),
        .o_mem_read(id_mem_read), .o_mem_write(id_mem_write),
        .o_is_branch(id_is_branch), .o_branch_op(id_branch_op)
    );

    regfile u_regfile (
        .i_clk(i_clk), .i_reset(i_reset), .i_write(wb_write), .i_rd(wb_rd),
        .i_wdata(wb_result), .i_rs1(id_rs1), .i_rs2(id_rs2),
        .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
    );

    hazard_unit u_hazard (
        .i_ex_rs1(ex_rs1), .i_ex_rs2(ex_rs2),
        .i_ex_uses_rs1(ex_uses_rs1), .i_ex_uses_rs2(ex_uses_rs2),
        .i_mem_rd(mem_rd), .i_mem_reg_write(mem_reg_write),
        .i_mem_is_load(mem_is_load), .i_mem_access(mem_access),
        .i_wb_rd(wb_rd), .i_wb_reg_write(wb_write),
        .i_i_mem_resp(i_i_mem_resp), .i_d_mem_resp(i_d_mem_resp),
        .o_fwd_a(fwd_a), .o_fwd_b(fwd_b), .o_load_front(load_front),
        .o_load_ex(load_ex), .o_load_mem(load_mem), .o_bubble_mem(bubble_mem)
    );

    // Taken branch squashes the decode slot on its way out of EX
    execute_stage u_execute (
        .i_clk(i_clk), .i_reset(i_reset), .i_load(load_ex), .i_flush(branch_taken),
        .i_rs1(id_rs1), .i_rs2(id_rs2), .i_rd(id_rd), .i_imm(id_imm),
        .i_alu_op(id_alu_op), .i_use_imm(id_use_imm),
        .i_uses_rs1(id_uses_rs1), .i_uses_rs2(id_uses_rs2),
        .i_reg_write(id_reg_write), .i_mem_read(id_mem_read), .i_mem_write(id_mem_write),
        .i_is_branch(id_is_branch), .i_branch_op(id_branch_op), .i_id_pc(id_pc),
        .i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .i_fwd_a(fwd_a), .i_fwd_b(fwd_b),
        .i_mem_result(mem_result), .i_wb_result(wb_result),
        .o_ex_rs1(ex_rs1), .o_ex_rs2(ex_rs2),
        .o_ex_uses_rs1(ex_uses_rs1), .o_ex_uses_rs2(ex_uses_rs2),
        .o_rd(ex_rd), .o_reg_write(ex_reg_write),
        .o_mem_read(ex_mem_read), .o_mem_write(ex_mem_write),
        .o_alu_result(ex_alu_result), .o_store_data(ex_store_data),
        .o_branch_taken(branch_taken), .o_branch_target(branch_target)
    );

    mem_wb_stage u_mem_wb (
        .i_clk(i_clk), .i_reset(i_reset), .i_load(load_mem), .i_bubble(bubble_mem),
        .i_rd(ex_rd), .i_reg_write(ex_reg_write),
        .i_mem_read(ex_mem_read), .i_mem_write(ex_mem_write),
        .i_alu_result(ex_alu_result), .i_store_data(ex_store_data),
        .i_d_mem_rdata(i_d_mem_rdata),
        .o_d_mem_address(o_d_mem_address), .o_d_mem_wdata(o_d_mem_wdata),
        .o_d_mem_read(o_d_mem_read), .o_d_mem_write(o_d_mem_write),
        .o_mem_access(mem_access), .o_mem_rd(mem_rd), .o_mem_reg_write(mem_reg_write),
        .o_mem_is_load(mem_is_load), .o_mem_result(mem_result),
        .o_wb_rd(wb_rd), .o_wb_write(wb_write), .o_wb_result(wb_result)
    );

endmodule

/* design/mem_wb_stage.sv */
`timescale 1ns/1ps

module mem_wb_stage (
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic              i_load,
    input  logic              i_bubble,
    input  rv_pkg::reg_addr_t i_rd,
    input  logic              i_reg_write,
    input  logic              i_mem_read,
    input  logic              i_mem_write,
    input  rv_pkg::word_t     i_alu_result,
    input  rv_pkg::word_t     i_store_data,
    input  rv_pkg::word_t     i_d_mem_rdata,
    output rv_pkg::word_t     o_d_mem_address,
    output rv_pkg::word_t     o_d_mem_wdata,
    output logic              o_d_mem_read,
    output logic              o_d_mem_write,
    output logic              o_mem_access,
    output rv_pkg::reg_addr_t o_mem_rd,
    output logic              o_mem_reg_write,
    output logic              o_mem_is_load,
    output rv_pkg::word_t     o_mem_result,
    output rv_pkg::reg_addr_t o_wb_rd,
    output logic              o_wb_write,
    output rv_pkg::word_t     o_wb_result
);

    logic mem_write;

    // EX/MEM controls
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_mem_reg_write <= 1'b0;
            o_mem_is_load   <= 1'b0;
            mem_write       <= 1'b0;
        end else if (i_load) begin
            o_mem_reg_write <= i_reg_write & ~i_bubble;
            o_mem_is_load   <= i_mem_read & ~i_bubble;
            mem_write       <= i_mem_write & ~i_bubble;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_load) begin
            o_mem_rd      <= i_rd;
            o_mem_result  <= i_alu_result;
            o_d_mem_wdata <= i_store_data;
        end
    end

    assign o_d_mem_address = {o_mem_result[31:2], 2'b00};
    assign o_d_mem_read    = o_mem_is_load;
    assign o_d_mem_write   = mem_write && i_load;  // One strobe per store even under a fetch stall
    assign o_mem_access    = o_mem_is_load || mem_write;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wb_write <= 1'b0;
        end else if (i_load) begin
            o_wb_write <= o_mem_reg_write;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_load) begin
            o_wb_rd     <= o_mem_rd;
            o_wb_result <= o_mem_is_load ? i_d_mem_rdata : o_mem_result;
        end
    end

endmodule

/* design/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic               i_clk,
    input  logic               i_reset,
    input  logic               i_load,
    input  logic               i_flush,
    input  rv_pkg::reg_addr_t  i_rs1,
    input  rv_pkg::reg_addr_t  i_rs2,
    input  rv_pkg::reg_addr_t  i_rd,
    input  rv_pkg::word_t      i_imm,
    input  rv_pkg::alu_op_t    i_alu_op,
    input  logic               i_use_imm,
    input  logic               i_uses_rs1,
    input  logic               i_uses_rs2,
    input  logic               i_reg_write,
    input  logic               i_mem_read,
    input  logic               i_mem_write,
    input  logic               i_is_branch,
    input  rv_pkg::branch_op_t i_branch_op,
    input  rv_pkg::word_t      i_id_pc,
    input  rv_pkg::word_t      i_rs1_data,
    input  rv_pkg::word_t      i_rs2_data,
    input  rv_pkg::fwd_sel_t   i_fwd_a,
    input  rv_pkg::fwd_sel_t   i_fwd_b,
    input  rv_pkg::word_t      i_mem_result,
    input  rv_pkg::word_t      i_wb_result,
    output rv_pkg::reg_addr_t  o_ex_rs1,
    output rv_pkg::reg_addr_t  o_ex_rs2,
    output logic               o_ex_uses_rs1,
    output logic               o_ex_uses_rs2,
    output rv_pkg::reg_addr_t  o_rd,
    output logic               o_reg_write,
    output logic               o_mem_read,
    output logic               o_mem_write,
    output rv_pkg::word_t      o_alu_result,
    output rv_pkg::word_t      o_store_data,
    output logic               o_branch_taken,
    output rv_pkg::word_t      o_branch_target
);

    rv_pkg::word_t      ex_pc;
    rv_pkg::word_t      ex_imm;
    rv_pkg::word_t      ex_rs1_data;
    rv_pkg::word_t      ex_rs2_data;
    rv_pkg::alu_op_t    ex_alu_op;
    rv_pkg::branch_op_t ex_branch_op;
    logic               ex_use_imm;
    logic               ex_is_branch;
    rv_pkg::word_t      op_a;
    rv_pkg::word_t      fwd_b_val;
    rv_pkg::word_t      op_b;
    logic               cond;

    function automatic rv_pkg::word_t pick(input rv_pkg::fwd_sel_t sel, input rv_pkg::word_t rf,
                                           input rv_pkg::word_t mem, input rv_pkg::word_t wb);
        case (sel)
            rv_pkg::FWD_MEM: return mem;
            rv_pkg::FWD_WB:  return wb;
            default:         return rf;
        endcase
    endfunction

    // A flush turns the ID/EX controls into a bubble
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_ex_uses_rs1 <= 1'b0;
            o_ex_uses_rs2 <= 1'b0;
            o_reg_write   <= 1'b0;
            o_mem_read    <= 1'b0;
            o_mem_write   <= 1'b0;
            ex_is_branch  <= 1'b0;
        end else if (i_load) begin
            o_ex_uses_rs1 <= i_uses_rs1 & ~i_flush;
            o_ex_uses_rs2 <= i_uses_rs2 & ~i_flush;
            o_reg_write   <= i_reg_write & ~i_flush;
            o_mem_read    <= i_mem_read & ~i_flush;
            o_mem_write   <= i_mem_write & ~i_flush;
            ex_is_branch  <= i_is_branch & ~i_flush;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_load) begin
            o_ex_rs1     <= i_rs1;
            o_ex_rs2     <= i_rs2;
            o_rd         <= i_rd;
            ex_pc        <= i_id_pc;
            ex_imm       <= i_imm;
            ex_rs1_data  <= i_rs1_data;
            ex_rs2_data  <= i_rs2_data;
            ex_alu_op    <= i_alu_op;
            ex_branch_op <= i_branch_op;
            ex_use_imm   <= i_use_imm;
        end else begin
            ex_rs1_data  <= op_a;  // Keeps a WB operand once its producer retires
            ex_rs2_data  <= fwd_b_val;
        end
    end

    assign op_a      = pick(i_fwd_a, ex_rs1_data, i_mem_result, i_wb_result);
    assign fwd_b_val = pick(i_fwd_b, ex_rs2_data, i_mem_result, i_wb_result);
    assign op_b      = ex_use_imm ? ex_imm : fwd_b_val;

    always_comb begin
        case (ex_alu_op)
            rv_pkg::ALU_SUB:    o_alu_result = op_a - op_b;
            rv_pkg::ALU_SLL:    o_alu_result = op_a << op_b[4:0];
            rv_pkg::ALU_SLT:    o_alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_SLTU:   o_alu_result = {31'b0, op_a < op_b};
            rv_pkg::ALU_XOR:    o_alu_result = op_a ^ op_b;
            rv_pkg::ALU_SRL:    o_alu_result = op_a >> op_b[4:0];
            rv_pkg::ALU_SRA:    o_alu_result = $signed(op_a) >>> op_b[4:0];
            rv_pkg::ALU_OR:     o_alu_result = op_a | op_b;
            rv_pkg::ALU_AND:    o_alu_result = op_a & op_b;
            rv_pkg::ALU_PASS_B: o_alu_result = op_b;
            default:            o_alu_result = op_a + op_b;
        endcase
    end

    // Branch comparator on the forwarded register values
    always_comb begin
        case (ex_branch_op)
            rv_pkg::BR_EQ:  cond = (op_a == fwd_b_val);
            rv_pkg::BR_NE:  cond = (op_a != fwd_b_val);
            rv_pkg::BR_LT:  cond = ($signed(op_a) < $signed(fwd_b_val));
            rv_pkg::BR_GE:  cond = ($signed(op_a) >= $signed(fwd_b_val));
            rv_pkg::BR_LTU: cond = (op_a < fwd_b_val);
            rv_pkg::BR_GEU: cond = (op_a >= fwd_b_val);
            default:        cond = 1'b0;
        endcase
    end

    assign o_store_data    = fwd_b_val;
    assign o_branch_target = ex_pc + ex_imm;
    assign o_branch_taken  = ex_is_branch && cond && i_load;  // Operands final only when EX moves

endmodule

/* design/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
    input  rv_pkg::reg_addr_t i_ex_rs1,
    input  rv_pkg::reg_addr_t i_ex_rs2,
    input  logic              i_ex_uses_rs1,
    input  logic              i_ex_uses_rs2,
    input  rv_pkg::reg_addr_t i_mem_rd,
    input  logic              i_mem_reg_write,
    input  logic              i_mem_is_load,
    input  logic              i_mem_access,
    input  rv_pkg::reg_addr_t i_wb_rd,
    input  logic              i_wb_reg_write,
    input  logic              i_i_mem_resp,
    input  logic              i_d_mem_resp,
    output rv_pkg::fwd_sel_t  o_fwd_a,
    output rv_pkg::fwd_sel_t  o_fwd_b,
    output logic              o_load_front,
    output logic              o_load_ex,
    output logic              o_load_mem,
    output logic              o_bubble_mem
);

    logic mem_hit_a;
    logic mem_hit_b;
    logic wb_hit_a;
    logic wb_hit_b;
    logic load_use;
    logic freeze;

    // Producer must write a nonzero register that the consumer really reads
    function automatic logic dest_match(input rv_pkg::reg_addr_t src, input logic uses,
                                        input rv_pkg::reg_addr_t rd, input logic wr);
        return uses && wr && (rd != '0) && (rd == src);
    endfunction

    assign mem_hit_a = dest_match(i_ex_rs1, i_ex_uses_rs1, i_mem_rd, i_mem_reg_write);
    assign mem_hit_b = dest_match(i_ex_rs2, i_ex_uses_rs2, i_mem_rd, i_mem_reg_write);
    assign wb_hit_a  = dest_match(i_ex_rs1, i_ex_uses_rs1, i_wb_rd, i_wb_reg_write);
    assign wb_hit_b  = dest_match(i_ex_rs2, i_ex_uses_rs2, i_wb_rd, i_wb_reg_write);

    // MEM is younger than WB, so it wins
    assign o_fwd_a = mem_hit_a ? rv_pkg::FWD_MEM : (wb_hit_a ? rv_pkg::FWD_WB : rv_pkg::FWD_NONE);
    assign o_fwd_b = mem_hit_b ? rv_pkg::FWD_MEM : (wb_hit_b ? rv_pkg::FWD_WB : rv_pkg::FWD_NONE);

    assign load_use = i_mem_is_load && (mem_hit_a || mem_hit_b);
    assign freeze   = !i_i_mem_resp || (!i_d_mem_resp && i_mem_access);

    assign o_load_front = !freeze && !load_use;
    assign o_load_ex    = !freeze && !load_use;
    assign o_load_mem   = !freeze;
    assign o_bubble_mem = !freeze && load_use;  // Load moves on while EX waits one cycle

endmodule

/* design/regfile.sv */
`timescale 1ns/1ps

module regfile (
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic              i_write,
    input  rv_pkg::reg_addr_t i_rd,
    input  rv_pkg::word_t     i_wdata,
    input  rv_pkg::reg_addr_t i_rs1,
    input  rv_pkg::reg_addr_t i_rs2,
    output rv_pkg::word_t     o_rs1_data,
    output rv_pkg::word_t     o_rs2_data
);

    rv_pkg::word_t regs [32];
    logic          wr_en;

    assign wr_en = i_write && (i_rd != '0);  // x0 never written

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // Same-cycle write is visible to decode
    assign o_rs1_data = (wr_en && i_rd == i_rs1) ? i_wdata : regs[i_rs1];
    assign o_rs2_data = (wr_en && i_rd == i_rs2) ? i_wdata : regs[i_rs2];

endmodule

/* design/decoder.sv */
`timescale 1ns/1ps

module decoder (
    input  rv_pkg::word_t      i_instr,
    output rv_pkg::reg_addr_t  o_rs1,
    output rv_pkg::reg_addr_t  o_rs2,
    output rv_pkg::reg_addr_t  o_rd,
    output rv_pkg::word_t      o_imm,
    output rv_pkg::alu_op_t    o_alu_op,
    output logic               o_use_imm,
    output logic               o_uses_rs1,
    output logic               o_uses_rs2,
    output logic               o_reg_write,
    output logic               o_mem_read,
    output logic               o_mem_write,
    output logic               o_is_branch,
    output rv_pkg::branch_op_t o_branch_op
);

    rv_pkg::opcode_t opcode;
    logic [2:0]      funct3;
    rv_pkg::word_t   imm_i;
    rv_pkg::word_t   imm_s;
    rv_pkg::word_t   imm_b;
    rv_pkg::word_t   imm_u;
    rv_pkg::alu_op_t arith_op;

    assign opcode      = rv_pkg::opcode_t'(i_instr[6:0]);
    assign funct3      = i_instr[14:12];
    assign o_rs1       = i_instr[19:15];
    assign o_rs2       = i_instr[24:20];
    assign o_rd        = i_instr[11:7];
    assign o_branch_op = rv_pkg::branch_op_t'(funct3);

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};

    // funct3 picks the ALU op and bit 30 selects SUB or SRA
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == rv_pkg::OP_REG && i_instr[30]) ? rv_pkg::ALU_SUB
                                                                           : rv_pkg::ALU_ADD;
            3'b001:  arith_op = rv_pkg::ALU_SLL;
            3'b010:  arith_op = rv_pkg::ALU_SLT;
            3'b011:  arith_op = rv_pkg::ALU_SLTU;
            3'b100:  arith_op = rv_pkg::ALU_XOR;
            3'b101:  arith_op = i_instr[30] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  arith_op = rv_pkg::ALU_OR;
            default: arith_op = rv_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        o_imm       = '0;
        o_alu_op    = rv_pkg::ALU_ADD;
        o_use_imm   = 1'b0;
        o_uses_rs1  = 1'b0;
        o_uses_rs2  = 1'b0;
        o_reg_write = 1'b0;
        o_mem_read  = 1'b0;
        o_mem_write = 1'b0;
        o_is_branch = 1'b0;
        case (opcode)
            rv_pkg::OP_LUI: begin
                o_imm       = imm_u;
                o_alu_op    = rv_pkg::ALU_PASS_B;
                o_use_imm   = 1'b1;
                o_reg_write = 1'b1;
            end
            rv_pkg::OP_IMM: begin
                o_imm       = imm_i;
                o_alu_op    = arith_op;
                o_use_imm   = 1'b1;
                o_uses_rs1  = 1'b1;
                o_reg_write = 1'b1;
            end
            rv_pkg::OP_REG: begin
                o_alu_op    = arith_op;
                o_uses_rs1  = 1'b1;
                o_uses_rs2  = 1'b1;
                o_reg_write = 1'b1;
            end
            rv_pkg::OP_LOAD: begin
                o_imm       = imm_i;
                o_use_imm   = 1'b1;
                o_uses_rs1  = 1'b1;
                o_reg_write = 1'b1;
                o_mem_read  = 1'b1;
            end
            rv_pkg::OP_STORE: begin
                o_imm       = imm_s;
                o_use_imm   = 1'b1;
                o_uses_rs1  = 1'b1;
                o_uses_rs2  = 1'b1;  // Store data
                o_mem_write = 1'b1;
            end
            rv_pkg::OP_BRANCH: begin
                o_imm       = imm_b;
                o_uses_rs1  = 1'b1;
                o_uses_rs2  = 1'b1;
                o_is_branch = 1'b1;
            end
            default: ;  // Anything else behaves as a no-op
        endcase
    end

endmodule

/* design/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
    input  logic          i_clk,
    input  logic          i_reset,
    input  logic          i_load,
    input  logic          i_branch_taken,
    input  rv_pkg::word_t i_branch_target,
    input  rv_pkg::word_t i_instr,
    output rv_pkg::word_t o_pc,
    output rv_pkg::word_t o_id_instr,
    output rv_pkg::word_t o_id_pc
);

    rv_pkg::word_t pc;
    rv_pkg::word_t next_pc;

    assign next_pc = i_branch_taken ? i_branch_target : pc + rv_pkg::PC_STEP;

    // Redirect wins over a held front
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pc         <= rv_pkg::RESET_PC;
            o_id_instr <= rv_pkg::NOP_INSTR;
        end else if (i_branch_taken) begin
            pc         <= next_pc;
            o_id_instr <= rv_pkg::NOP_INSTR;  // Kill wrong-path fetch
        end else if (i_load) begin
            pc         <= next_pc;
            o_id_instr <= i_instr;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_load) begin
            o_id_pc <= pc;
        end
    end

    assign o_pc = pc;

endmodule

/* design/rv_pkg.sv */
package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    localparam word_t RESET_PC  = 32'h0000_0000;
    localparam word_t PC_STEP   = 32'd4;
    localparam word_t NOP_INSTR = 32'h0000_0013;  // ADDI x0, x0, 0

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B  // LUI result
    } alu_op_t;

    // Encoded as funct3 of the branch instructions
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branch_op_t;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

endpackage
